// File: hdl/idu_pkg.sv
// decode stage package with widths, op codes, csr addresses and stage structs
package idu_pkg;

    localparam int xlen       = 64;    // register and pc width
    localparam int ilen       = 32;    // instruction width
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // machine csr addresses
    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;

    // rv64i major opcodes
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;
    localparam logic [6:0] opc_system    = 7'b1110011;

    typedef logic [xlen-1:0]       xlen_t;
    typedef logic [ilen-1:0]       inst_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef xlen_t [num_regs-1:0]  gpr_file_t;    // whole register file

    typedef enum logic [5:0] {
        op_none,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi, op_slli, op_srli, op_srai,
        op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_or, op_and,
        op_addiw, op_slliw, op_srliw, op_sraiw, op_addw, op_subw, op_sllw, op_srlw, op_sraw,
        op_csrrw, op_csrrs
    } op_e;

    typedef enum logic [2:0] {
        fmt_i, fmt_s, fmt_b, fmt_u, fmt_j
    } imm_fmt_e;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } stage_t;    // 97 bits

    typedef struct packed {
        xlen_t mstatus;
        xlen_t mtvec;
        xlen_t mepc;
        xlen_t mcause;
    } csr_file_t;

    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        imm_fmt_e  imm_fmt;
        logic      wen;         // writes rd
        logic      uses_rs2;    // reads rs2 as a register operand
    } decode_t;

endpackage

// File: hdl/id_stage_reg.sv
// fetch-to-decode pipeline register with hold and flush
`timescale 1ns/1ps

module id_stage_reg (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,    // one cycle pulse, wins over load
    input  logic            load,     // capture d this edge
    input  idu_pkg::stage_t d,
    output idu_pkg::stage_t q
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;    // drop valid, pc and inst
        end else if (load) begin
            q <= d;
        end
        // no load so contents hold
    end

endmodule

// File: hdl/inst_decoder.sv
// rv64i plus csrrw/csrrs instruction decoder giving op, fields, imm format and flags
`timescale 1ns/1ps

module inst_decoder (
    input  idu_pkg::inst_t   inst,
    output idu_pkg::decode_t dec
);

    logic [6:0]       opcode;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic [5:0]       f6;    // rv64 immediate shifts use a 6-bit shamt
    idu_pkg::op_e     op;
    idu_pkg::imm_fmt_e fmt;

    assign opcode = inst[6:0];
    assign f3     = inst[14:12];
    assign f7     = inst[31:25];
    assign f6     = inst[31:26];

    always_comb begin
        op = idu_pkg::op_none;    // anything unlisted
        case (opcode)
            idu_pkg::opc_lui:   op = idu_pkg::op_lui;
            idu_pkg::opc_auipc: op = idu_pkg::op_auipc;
            idu_pkg::opc_jal:   op = idu_pkg::op_jal;
            idu_pkg::opc_jalr:  if (f3 == 3'b000) op = idu_pkg::op_jalr;
            idu_pkg::opc_branch: begin
                case (f3)
                    3'b000:  op = idu_pkg::op_beq;
                    3'b001:  op = idu_pkg::op_bne;
                    3'b100:  op = idu_pkg::op_blt;
                    3'b101:  op = idu_pkg::op_bge;
                    3'b110:  op = idu_pkg::op_bltu;
                    3'b111:  op = idu_pkg::op_bgeu;
                    default: op = idu_pkg::op_none;
                endcase
            end
            idu_pkg::opc_load: begin
                case (f3)
                    3'b000:  op = idu_pkg::op_lb;
                    3'b001:  op = idu_pkg::op_lh;
                    3'b010:  op = idu_pkg::op_lw;
                    3'b011:  op = idu_pkg::op_ld;
                    3'b100:  op = idu_pkg::op_lbu;
                    3'b101:  op = idu_pkg::op_lhu;
                    3'b110:  op = idu_pkg::op_lwu;
                    default: op = idu_pkg::op_none;
                endcase
            end
            idu_pkg::opc_store: begin
                case (f3)
                    3'b000:  op = idu_pkg::op_sb;
                    3'b001:  op = idu_pkg::op_sh;
                    3'b010:  op = idu_pkg::op_sw;
                    3'b011:  op = idu_pkg::op_sd;
                    default: op = idu_pkg::op_none;
                endcase
            end
            idu_pkg::opc_op_imm: begin
                case (f3)
                    3'b000:  op = idu_pkg::op_addi;
                    3'b010:  op = idu_pkg::op_slti;
                    3'b011:  op = idu_pkg::op_sltiu;
                    3'b100:  op = idu_pkg::op_xori;
                    3'b110:  op = idu_pkg::op_ori;
                    3'b111:  op = idu_pkg::op_andi;
                    3'b001:  if (f6 == 6'b000000) op = idu_pkg::op_slli;
                    3'b101: begin
                        if (f6 == 6'b000000) op = idu_pkg::op_srli;
                        else if (f6 == 6'b010000) op = idu_pkg::op_srai;
                    end
                    default: op = idu_pkg::op_none;
                endcase
            end
            idu_pkg::opc_op: begin
                case ({f7, f3})
                    10'b0000000_000: op = idu_pkg::op_add;
                    10'b0100000_000: op = idu_pkg::op_sub;
                    10'b0000000_001: op = idu_pkg::op_sll;
                    10'b0000000_010: op = idu_pkg::op_slt;
                    10'b0000000_011: op = idu_pkg::op_sltu;
                    10'b0000000_100: op = idu_pkg::op_xor;
                    10'b0000000_101: op = idu_pkg::op_srl;
                    10'b0000000_110: op = idu_pkg::op_or;
                    10'b0000000_111: op = idu_pkg::op_and;
                    default:         op = idu_pkg::op_none;    // no sra, no m ext
                endcase
            end
            idu_pkg::opc_op_imm_32: begin
                case (f3)
                    3'b000:  op = idu_pkg::op_addiw;
                    3'b001:  if (f7 == 7'b0000000) op = idu_pkg::op_slliw;
                    3'b101: begin
                        if (f7 == 7'b0000000) op = idu_pkg::op_srliw;
                        else if (f7 == 7'b0100000) op = idu_pkg::op_sraiw;
                    end
                    default: op = idu_pkg::op_none;
                endcase
            end
            idu_pkg::opc_op_32: begin
                case ({f7, f3})
                    10'b0000000_000: op = idu_pkg::op_addw;
                    10'b0100000_000: op = idu_pkg::op_subw;
                    10'b0000000_001: op = idu_pkg::op_sllw;
                    10'b0000000_101: op = idu_pkg::op_srlw;
                    10'b0100000_101: op = idu_pkg::op_sraw;
                    default:         op = idu_pkg::op_none;
                endcase
            end
            idu_pkg::opc_system: begin
                if (f3 == 3'b001) op = idu_pkg::op_csrrw;
                else if (f3 == 3'b010) op = idu_pkg::op_csrrs;
            end
            default: op = idu_pkg::op_none;
        endcase
    end

    // immediate format follows the decoded op
    always_comb begin
        case (op)
            idu_pkg::op_lui, idu_pkg::op_auipc: fmt = idu_pkg::fmt_u;
            idu_pkg::op_jal:                    fmt = idu_pkg::fmt_j;
            idu_pkg::op_sb, idu_pkg::op_sh, idu_pkg::op_sw, idu_pkg::op_sd:
                fmt = idu_pkg::fmt_s;
            idu_pkg::op_beq, idu_pkg::op_bne, idu_pkg::op_blt,
            idu_pkg::op_bge, idu_pkg::op_bltu, idu_pkg::op_bgeu:
                fmt = idu_pkg::fmt_b;
            default: fmt = idu_pkg::fmt_i;    // loads, alu imm, jalr, csr, none
        endcase
    end

    assign dec.op      = op;
    assign dec.rd      = inst[11:7];
    assign dec.rs1     = inst[19:15];
    assign dec.rs2     = inst[24:20];
    assign dec.imm_fmt = fmt;
    assign dec.wen     = (op != idu_pkg::op_none) && (fmt != idu_pkg::fmt_b)
                         && (fmt != idu_pkg::fmt_s);    // no rd for branch/store
    assign dec.uses_rs2 = (fmt == idu_pkg::fmt_b)
                          || (opcode == idu_pkg::opc_op && op != idu_pkg::op_none)
                          || (opcode == idu_pkg::opc_op_32 && op != idu_pkg::op_none);

endmodule

// File: hdl/imm_gen.sv
// sign-extended 64-bit immediate builder for the i, s, b, u and j formats
`timescale 1ns/1ps

module imm_gen (
    input  idu_pkg::inst_t    inst,
    input  idu_pkg::imm_fmt_e fmt,
    output idu_pkg::xlen_t    imm
);

    idu_pkg::xlen_t imm_i;
    idu_pkg::xlen_t imm_s;
    idu_pkg::xlen_t imm_b;
    idu_pkg::xlen_t imm_u;
    idu_pkg::xlen_t imm_j;

    // all formats take the sign from inst[31]
    assign imm_i = {{(idu_pkg::xlen-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(idu_pkg::xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(idu_pkg::xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};    // halfword aligned
    assign imm_u = {{(idu_pkg::xlen-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(idu_pkg::xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};

    always_comb begin
        case (fmt)
            idu_pkg::fmt_s: imm = imm_s;
            idu_pkg::fmt_b: imm = imm_b;
            idu_pkg::fmt_u: imm = imm_u;
            idu_pkg::fmt_j: imm = imm_j;
            default:        imm = imm_i;    // fmt_i and unused codes
        endcase
    end

endmodule

// File: hdl/load_use_interlock.sv
// load-use hazard detect between the execute-stage load and the decode sources
`timescale 1ns/1ps

module load_use_interlock (
    input  logic               id_valid,
    input  idu_pkg::reg_addr_t id_rs1,
    input  idu_pkg::reg_addr_t id_rs2,
    input  logic               id_uses_rs2,
    input  idu_pkg::stage_t    ex,
    output logic               block
);

    logic               ex_load;
    idu_pkg::reg_addr_t ex_rd;
    logic               rs1_match;
    logic               rs2_match;

    // every funct3 except 3'b111 is a legal load
    assign ex_load = (ex.inst[6:0] == idu_pkg::opc_load) && (ex.inst[14:12] != 3'b111);
    assign ex_rd   = ex.inst[11:7];

    assign rs1_match = (ex_rd == id_rs1);    // x0 not exempt
    assign rs2_match = (ex_rd == id_rs2) && id_uses_rs2;

    assign block = id_valid && ex.valid && ex_load && (rs1_match || rs2_match);

endmodule

// File: hdl/operand_select.sv
// source operand read from the register file, src_b also from the csr file
`timescale 1ns/1ps

module operand_select (
    input  idu_pkg::gpr_file_t gpr,
    input  idu_pkg::csr_file_t csr,
    input  idu_pkg::reg_addr_t rs1,
    input  idu_pkg::reg_addr_t rs2,
    input  idu_pkg::op_e       op,
    input  logic [11:0]        csr_addr,
    output idu_pkg::xlen_t     src_a,
    output idu_pkg::xlen_t     src_b
);

    idu_pkg::xlen_t csr_val;

    always_comb begin
        case (csr_addr)
            idu_pkg::csr_mstatus: csr_val = csr.mstatus;
            idu_pkg::csr_mtvec:   csr_val = csr.mtvec;
            idu_pkg::csr_mepc:    csr_val = csr.mepc;
            idu_pkg::csr_mcause:  csr_val = csr.mcause;
            default:              csr_val = '0;    // unknown csr reads zero
        endcase
    end

    assign src_a = gpr[rs1];
    assign src_b = (op == idu_pkg::op_csrrw || op == idu_pkg::op_csrrs) ? csr_val : gpr[rs2];

endmodule

// File: hdl/idu_top.sv
// rv64i decode stage with stage register, decoder, immediates, operands and load interlock
`timescale 1ns/1ps

module idu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  idu_pkg::stage_t     in,
    output logic                ready_in,
    output idu_pkg::stage_t     out,
    input  logic                ready_out,
    input  idu_pkg::stage_t     ex,
    input  idu_pkg::gpr_file_t  gpr,
    input  idu_pkg::csr_file_t  csr,
    output idu_pkg::op_e        op,
    output idu_pkg::reg_addr_t  rd,
    output logic                wen,
    output idu_pkg::xlen_t      imm,
    output idu_pkg::xlen_t      src_a,
    output idu_pkg::xlen_t      src_b
);

    idu_pkg::stage_t  id_q;      // registered fetch word
    idu_pkg::inst_t   id_inst;
    idu_pkg::decode_t dec;
    logic             block;

    id_stage_reg i_stage_reg (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .load  (ready_in),    // accept on every ready edge
        .d     (in),
        .q     (id_q)
    );

    assign id_inst = id_q.valid ? id_q.inst : '0;    // empty slot decodes as op_none

    inst_decoder i_decoder (
        .inst (id_inst),
        .dec  (dec)
    );

    imm_gen i_imm_gen (
        .inst (id_inst),
        .fmt  (dec.imm_fmt),
        .imm  (imm)
    );

    load_use_interlock i_interlock (
        .id_valid    (id_q.valid),
        .id_rs1      (dec.rs1),
        .id_rs2      (dec.rs2),
        .id_uses_rs2 (dec.uses_rs2),
        .ex          (ex),
        .block       (block)
    );

    operand_select i_operands (
        .gpr      (gpr),
        .csr      (csr),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .op       (dec.op),
        .csr_addr (id_inst[31:20]),    // low 12 bits of the i immediate
        .src_a    (src_a),
        .src_b    (src_b)
    );

    // hazard holds the register and sends a bubble downstream
    assign ready_in = block ? 1'b0 : ready_out;
    assign out      = block ? '0 : id_q;

    assign op  = dec.op;
    assign rd  = dec.rd;
    assign wen = dec.wen;

endmodule

// File: tests/idu_properties.sv
// bound assertions on the decode stage hazard block, flush and stall hold
`timescale 1ns/1ps

module idu_properties (
    input logic            clk,
    input logic            rst,
    input logic            flush,
    input logic            ready_in,
    input logic            out_valid,
    input idu_pkg::stage_t ex,
    input idu_pkg::stage_t id_q
);

    int   fails = 0;    // failed assertion count
    logic rs1_hazard;   // execute load writes the decode rs1

    assign rs1_hazard = id_q.valid && ex.valid && ex.inst[6:0] == idu_pkg::opc_load
                        && ex.inst[14:12] inside {3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6}
                        && ex.inst[11:7] == id_q.inst[19:15];

    block_gates_out: assert property (@(posedge clk) disable iff (rst)
        rs1_hazard |-> !ready_in && !out_valid)
        else begin
            fails++;
            $error("hazard block active while ready_in or out.valid is high");
        end

    flush_clears: assert property (@(posedge clk) disable iff (rst)
        flush |=> !out_valid)
        else begin
            fails++;
            $error("out.valid still high one cycle after a flush");
        end

    stall_holds: assert property (@(posedge clk) disable iff (rst)
        !ready_in && !flush |=> $stable(id_q))
        else begin
            fails++;
            $error("stage register changed while ready_in was low");
        end

endmodule

bind idu_top idu_properties i_props (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .ready_in  (ready_in),
    .out_valid (out.valid),
    .ex        (ex),
    .id_q      (id_q)
);

// File: tests/idu_checker.sv
// decode stage reference model and output comparison
`timescale 1ns/1ps

module idu_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  idu_pkg::stage_t    in,
    input  idu_pkg::op_e       in_op,    // op the stimulus built into in.inst
    input  logic               ready_in,
    input  idu_pkg::stage_t    out,
    input  logic               ready_out,
    input  idu_pkg::stage_t    ex,
    input  idu_pkg::gpr_file_t gpr,
    input  idu_pkg::csr_file_t csr,
    input  idu_pkg::op_e       op,
    input  idu_pkg::reg_addr_t rd,
    input  logic               wen,
    input  idu_pkg::xlen_t     imm,
    input  idu_pkg::xlen_t     src_a,
    input  idu_pkg::xlen_t     src_b,
    output int                 errors,
    output int                 accepted
);

    idu_pkg::stage_t held;       // model of the stage register
    idu_pkg::op_e    held_op;
    idu_pkg::inst_t  e_inst;
    idu_pkg::op_e    e_op;
    logic            e_branch;
    logic            e_store;
    logic            e_csr;
    logic            e_rs2_used;
    logic            ex_load;
    logic            e_block;
    logic            e_ready;
    idu_pkg::stage_t e_out;

    // immediate by arithmetic shift of the bits placed at the top
    function automatic idu_pkg::xlen_t expect_imm(idu_pkg::op_e o, idu_pkg::inst_t w);
        logic signed [31:0] s;
        if (o == idu_pkg::op_lui || o == idu_pkg::op_auipc) begin
            s = {w[31:12], 12'b0};
        end else if (o == idu_pkg::op_jal) begin
            s = {w[31], w[19:12], w[20], w[30:21], 12'b0};
            s = s >>> 11;    // imm[1] lands on bit 1
        end else if (o >= idu_pkg::op_beq && o <= idu_pkg::op_bgeu) begin
            s = {w[31], w[7], w[30:25], w[11:8], 20'b0};
            s = s >>> 19;
        end else if (o >= idu_pkg::op_sb && o <= idu_pkg::op_sd) begin
            s = {w[31:25], w[11:7], 20'b0};
            s = s >>> 20;
        end else begin
            s = w;
            s = s >>> 20;    // i format
        end
        return {{32{s[31]}}, s};
    endfunction

    function automatic idu_pkg::xlen_t csr_read(logic [11:0] addr);
        case (addr)
            idu_pkg::csr_mstatus: return csr.mstatus;
            idu_pkg::csr_mtvec:   return csr.mtvec;
            idu_pkg::csr_mepc:    return csr.mepc;
            idu_pkg::csr_mcause:  return csr.mcause;
            default:              return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            errors = errors + 1;
            $display("ERROR %s at %0t: expected %h actual %h", name, $time, exp, act);
        end
    endtask

    always_comb begin
        e_inst     = held.valid ? held.inst : '0;    // empty slot counts as zero
        e_op       = held.valid ? held_op : idu_pkg::op_none;
        e_branch   = e_op >= idu_pkg::op_beq && e_op <= idu_pkg::op_bgeu;
        e_store    = e_op >= idu_pkg::op_sb && e_op <= idu_pkg::op_sd;
        e_csr      = e_op == idu_pkg::op_csrrw || e_op == idu_pkg::op_csrrs;
        e_rs2_used = e_branch || (e_op >= idu_pkg::op_add && e_op <= idu_pkg::op_and)
                     || (e_op >= idu_pkg::op_addw && e_op <= idu_pkg::op_sraw);
        ex_load    = ex.inst[6:0] == idu_pkg::opc_load
                     && ex.inst[14:12] inside {3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6};
        e_block    = held.valid && ex.valid && ex_load
                     && (ex.inst[11:7] == e_inst[19:15]
                         || (e_rs2_used && ex.inst[11:7] == e_inst[24:20]));
        e_ready    = !e_block && ready_out;
        e_out      = e_block ? '0 : held;    // bubble during a hazard
    end

    always @(posedge clk) begin
        if (!rst) begin
            check_value("op", e_op, op);
            check_value("rd", e_inst[11:7], rd);
            check_value("wen", e_op != idu_pkg::op_none && !e_branch && !e_store, wen);
            check_value("imm", expect_imm(e_op, e_inst), imm);
            check_value("src_a", gpr[e_inst[19:15]], src_a);
            check_value("src_b", e_csr ? csr_read(e_inst[31:20]) : gpr[e_inst[24:20]], src_b);
            check_value("ready_in", e_ready, ready_in);
            check_value("out.valid", e_out.valid, out.valid);
            check_value("out.pc", e_out.pc, out.pc);
            check_value("out.inst", e_out.inst, out.inst);
        end
        if (rst || flush) begin
            held    <= '0;    // flush wins over load
            held_op <= idu_pkg::op_none;
        end else if (e_ready) begin
            held    <= in;
            held_op <= in_op;
            if (in.valid) accepted = accepted + 1;
        end
    end

endmodule

// File: tests/idu_tb.sv
// decode stage testbench with lfsr stimulus, model checker and closing result line
`timescale 1ns/1ps

module idu_tb;

    localparam int          num_words   = 2000;
    localparam int          cycle_limit = num_words * 6;    // about 3x the expected run
    localparam logic [31:0] lfsr_seed   = 32'h265c8490;
    localparam logic [31:0] lfsr_taps   = 32'h80200003;

    logic               clk;
    logic               rst;
    logic               flush;
    idu_pkg::stage_t    in;
    idu_pkg::op_e       in_op;
    logic               ready_in;
    idu_pkg::stage_t    out;
    logic               ready_out;
    idu_pkg::stage_t    ex;
    idu_pkg::gpr_file_t gpr;
    idu_pkg::csr_file_t csr;
    idu_pkg::op_e       op;
    idu_pkg::reg_addr_t rd;
    logic               wen;
    idu_pkg::xlen_t     imm;
    idu_pkg::xlen_t     src_a;
    idu_pkg::xlen_t     src_b;
    int                 check_errors;
    int                 accepted;
    int                 cycles;
    logic [31:0]        lfsr_state;
    idu_pkg::stage_t    decode_word;    // shadow of the stage register that steers ex rd

    idu_top i_dut (.*);

    idu_checker i_checker (
        .errors (check_errors),
        .*
    );

    // galois lfsr stepped once per bit handed out
    function automatic logic [63:0] take_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ lfsr_taps : lfsr_state >> 1;
        end
        return v;
    endfunction

    // f7, f3, fixed-bit class, opcode
    function automatic logic [18:0] op_fields(idu_pkg::op_e o);
        case (o)
            idu_pkg::op_lui:   return {7'h00, 3'd0, 2'd0, idu_pkg::opc_lui};
            idu_pkg::op_auipc: return {7'h00, 3'd0, 2'd0, idu_pkg::opc_auipc};
            idu_pkg::op_jal:   return {7'h00, 3'd0, 2'd0, idu_pkg::opc_jal};
            idu_pkg::op_jalr:  return {7'h00, 3'd0, 2'd1, idu_pkg::opc_jalr};
            idu_pkg::op_beq:   return {7'h00, 3'd0, 2'd1, idu_pkg::opc_branch};
            idu_pkg::op_bne:   return {7'h00, 3'd1, 2'd1, idu_pkg::opc_branch};
            idu_pkg::op_blt:   return {7'h00, 3'd4, 2'd1, idu_pkg::opc_branch};
            idu_pkg::op_bge:   return {7'h00, 3'd5, 2'd1, idu_pkg::opc_branch};
            idu_pkg::op_bltu:  return {7'h00, 3'd6, 2'd1, idu_pkg::opc_branch};
            idu_pkg::op_bgeu:  return {7'h00, 3'd7, 2'd1, idu_pkg::opc_branch};
            idu_pkg::op_lb:    return {7'h00, 3'd0, 2'd1, idu_pkg::opc_load};
            idu_pkg::op_lh:    return {7'h00, 3'd1, 2'd1, idu_pkg::opc_load};
            idu_pkg::op_lw:    return {7'h00, 3'd2, 2'd1, idu_pkg::opc_load};
            idu_pkg::op_ld:    return {7'h00, 3'd3, 2'd1, idu_pkg::opc_load};
            idu_pkg::op_lbu:   return {7'h00, 3'd4, 2'd1, idu_pkg::opc_load};
            idu_pkg::op_lhu:   return {7'h00, 3'd5, 2'd1, idu_pkg::opc_load};
            idu_pkg::op_lwu:   return {7'h00, 3'd6, 2'd1, idu_pkg::opc_load};
            idu_pkg::op_sb:    return {7'h00, 3'd0, 2'd1, idu_pkg::opc_store};
            idu_pkg::op_sh:    return {7'h00, 3'd1, 2'd1, idu_pkg::opc_store};
            idu_pkg::op_sw:    return {7'h00, 3'd2, 2'd1, idu_pkg::opc_store};
            idu_pkg::op_sd:    return {7'h00, 3'd3, 2'd1, idu_pkg::opc_store};
            idu_pkg::op_addi:  return {7'h00, 3'd0, 2'd1, idu_pkg::opc_op_imm};
            idu_pkg::op_slti:  return {7'h00, 3'd2, 2'd1, idu_pkg::opc_op_imm};
            idu_pkg::op_sltiu: return {7'h00, 3'd3, 2'd1, idu_pkg::opc_op_imm};
            idu_pkg::op_xori:  return {7'h00, 3'd4, 2'd1, idu_pkg::opc_op_imm};
            idu_pkg::op_ori:   return {7'h00, 3'd6, 2'd1, idu_pkg::opc_op_imm};
            idu_pkg::op_andi:  return {7'h00, 3'd7, 2'd1, idu_pkg::opc_op_imm};
            idu_pkg::op_slli:  return {7'h00, 3'd1, 2'd2, idu_pkg::opc_op_imm};    // 6-bit shamt
            idu_pkg::op_srli:  return {7'h00, 3'd5, 2'd2, idu_pkg::opc_op_imm};
            idu_pkg::op_srai:  return {7'h20, 3'd5, 2'd2, idu_pkg::opc_op_imm};
            idu_pkg::op_add:   return {7'h00, 3'd0, 2'd3, idu_pkg::opc_op};
            idu_pkg::op_sub:   return {7'h20, 3'd0, 2'd3, idu_pkg::opc_op};
            idu_pkg::op_sll:   return {7'h00, 3'd1, 2'd3, idu_pkg::opc_op};
            idu_pkg::op_slt:   return {7'h00, 3'd2, 2'd3, idu_pkg::opc_op};
            idu_pkg::op_sltu:  return {7'h00, 3'd3, 2'd3, idu_pkg::opc_op};
            idu_pkg::op_xor:   return {7'h00, 3'd4, 2'd3, idu_pkg::opc_op};
            idu_pkg::op_srl:   return {7'h00, 3'd5, 2'd3, idu_pkg::opc_op};
            idu_pkg::op_or:    return {7'h00, 3'd6, 2'd3, idu_pkg::opc_op};
            idu_pkg::op_and:   return {7'h00, 3'd7, 2'd3, idu_pkg::opc_op};
            idu_pkg::op_addiw: return {7'h00, 3'd0, 2'd1, idu_pkg::opc_op_imm_32};
            idu_pkg::op_slliw: return {7'h00, 3'd1, 2'd3, idu_pkg::opc_op_imm_32};
            idu_pkg::op_srliw: return {7'h00, 3'd5, 2'd3, idu_pkg::opc_op_imm_32};
            idu_pkg::op_sraiw: return {7'h20, 3'd5, 2'd3, idu_pkg::opc_op_imm_32};
            idu_pkg::op_addw:  return {7'h00, 3'd0, 2'd3, idu_pkg::opc_op_32};
            idu_pkg::op_subw:  return {7'h20, 3'd0, 2'd3, idu_pkg::opc_op_32};
            idu_pkg::op_sllw:  return {7'h00, 3'd1, 2'd3, idu_pkg::opc_op_32};
            idu_pkg::op_srlw:  return {7'h00, 3'd5, 2'd3, idu_pkg::opc_op_32};
            idu_pkg::op_sraw:  return {7'h20, 3'd5, 2'd3, idu_pkg::opc_op_32};
            idu_pkg::op_csrrw: return {7'h00, 3'd1, 2'd1, idu_pkg::opc_system};
            idu_pkg::op_csrrs: return {7'h00, 3'd2, 2'd1, idu_pkg::opc_system};
            default:           return '0;
        endcase
    endfunction

    // fixed bits from the template and the rest from fill
    function automatic idu_pkg::inst_t template_word(idu_pkg::op_e o, idu_pkg::inst_t fill);
        logic [18:0]    f;
        idu_pkg::inst_t match;
        idu_pkg::inst_t mask;
        f     = op_fields(o);
        match = {f[18:12], 10'b0, f[11:9], 5'b0, f[6:0]};
        case (f[8:7])
            2'd0:    mask = 32'h0000007f;    // opcode only
            2'd1:    mask = 32'h0000707f;    // plus funct3
            2'd2:    mask = 32'hfc00707f;    // plus funct6
            default: mask = 32'hfe00707f;    // plus funct7
        endcase
        return match | (fill & ~mask);
    endfunction

    task automatic drive_inputs();
        logic [7:0]     pick;
        idu_pkg::inst_t w;
        idu_pkg::inst_t src;
        pick = 8'(take_bits(8));
        if (pick < 8'd250) begin
            in_op = idu_pkg::op_e'(pick % 50 + 1);
            w     = template_word(in_op, 32'(take_bits(32)));
            if ((in_op == idu_pkg::op_csrrw || in_op == idu_pkg::op_csrrs)
                && take_bits(1) != 0) begin
                case (2'(take_bits(2)))    // steer toward a known csr
                    2'd0:    w[31:20] = idu_pkg::csr_mstatus;
                    2'd1:    w[31:20] = idu_pkg::csr_mtvec;
                    2'd2:    w[31:20] = idu_pkg::csr_mepc;
                    default: w[31:20] = idu_pkg::csr_mcause;
                endcase
            end
        end else begin
            in_op = idu_pkg::op_none;
            w     = {30'(take_bits(30)), 2'b00};    // quadrant 0 is never rv64i
        end
        in.inst   = w;
        in.valid  = take_bits(2) != 0;
        in.pc     = take_bits(62) << 2;
        ready_out = take_bits(2) != 0;
        ex.valid  = take_bits(1) != 0;
        ex.pc     = '0;
        ex.inst   = 32'(take_bits(32));
        src       = decode_word.valid ? decode_word.inst : '0;
        if (take_bits(1) != 0) begin
            ex.inst[6:0]  = idu_pkg::opc_load;    // funct3 stays random so 3'b111 is no load
            ex.inst[11:7] = (take_bits(1) != 0) ? src[24:20] : src[19:15];
        end
        flush = take_bits(5) == 0;    // about 3 percent
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst || flush) decode_word <= '0;
        else if (ready_in) decode_word <= in;
    end

    initial begin : stimulus
        lfsr_state = lfsr_seed;
        rst        = 1'b1;
        flush      = 1'b0;
        in         = '0;
        in_op      = idu_pkg::op_none;
        ready_out  = 1'b0;
        ex         = '0;
        gpr        = '0;
        csr        = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < idu_pkg::num_regs; r++) begin
            gpr[r] = take_bits(64);
        end
        csr.mstatus = take_bits(64);
        csr.mtvec   = take_bits(64);
        csr.mepc    = take_bits(64);
        csr.mcause  = take_bits(64);
        forever begin
            drive_inputs();
            @(negedge clk);
        end
    end

    initial begin : run_control
        cycles = 0;
        while (accepted < num_words && cycles < cycle_limit) begin
            @(negedge clk);    // counts settle after the rising edge
            cycles++;
        end
        $display("words %0d, check errors %0d, assertion failures %0d",
                 accepted, check_errors, i_dut.i_props.fails);
        if (accepted < num_words) begin
            $display("timeout: only %0d of %0d words accepted in %0d cycles",
                     accepted, num_words, cycles);
        end
        if (accepted >= num_words && check_errors == 0 && i_dut.i_props.fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
hdl/idu_pkg.sv
hdl/id_stage_reg.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/load_use_interlock.sv
hdl/operand_select.sv
hdl/idu_top.sv
tests/idu_properties.sv
tests/idu_checker.sv
tests/idu_tb.sv

// File: Bender.yml
package:
  name: idu

sources:
  - hdl/idu_pkg.sv
  - hdl/id_stage_reg.sv
  - hdl/inst_decoder.sv
  - hdl/imm_gen.sv
  - hdl/load_use_interlock.sv
  - hdl/operand_select.sv
  - hdl/idu_top.sv
  - target: test
    files:
      - tests/idu_properties.sv
      - tests/idu_checker.sv
      - tests/idu_tb.sv
